// File: hw/rv32i_pkg.sv
`default_nettype none

package rv32i_pkg;

  // ******************************
  // basic types
  // ******************************

  typedef logic [31:0] word_t; // one data word.

  // source of the register write value.
  typedef enum logic [1:0] {
    rd_alu  = 2'b00, // alu result.
    rd_load = 2'b01, // extended load data.
    rd_pc4  = 2'b10, // link value.
    rd_br   = 2'b11  // branch flag, zero-extended.
  } rd_src_t;

  // ******************************
  // control word
  // ******************************

  // travels with the instruction down the pipe. all zeros is a bubble.
  typedef struct packed {
    logic       mem_read;  // load request.
    logic       mem_write; // store request.
    logic [2:0] funct3;    // access width and sign.
    rd_src_t    rd_src;    // write value select.
    logic [4:0] rd;        // destination register.
    logic       reg_we;    // register write enable.
  } ctrl_word_t;

  // ******************************
  // load/store funct3 codes
  // ******************************

  localparam logic [2:0] F3_B  = 3'b000; // byte, signed on load.
  localparam logic [2:0] F3_H  = 3'b001; // half, signed on load.
  localparam logic [2:0] F3_W  = 3'b010; // full word.
  localparam logic [2:0] F3_BU = 3'b100; // byte, zero-extended.
  localparam logic [2:0] F3_HU = 3'b101; // half, zero-extended.

endpackage

`default_nettype wire

// File: hw/dmem_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dmem_if;

  rv32i_pkg::word_t addr;  // word aligned.
  rv32i_pkg::word_t wdata; // lane-shifted store data.
  logic [3:0]       mbe;   // byte enables.
  logic             read;  // held while pending.
  logic             write; // held while pending.
  rv32i_pkg::word_t rdata; // valid with resp.
  logic             resp;  // one-cycle done strobe.

  // memory stage side.
  modport stage (output addr, wdata, mbe, read, write,
                 input  rdata, resp);

  // memory side.
  modport mem (input  addr, wdata, mbe, read, write,
               output rdata, resp);

endinterface

`default_nettype wire

// File: hw/store_align.sv
`timescale 1ns/1ps
`default_nettype none

module store_align (
  input  wire logic [2:0]       funct3,
  input  wire logic [1:0]       addr_lo,
  input  wire rv32i_pkg::word_t rs2,
  output rv32i_pkg::word_t      wdata,
  output logic [3:0]            mbe
);

  // the memory only looks at the enabled lanes, so the data is
  // replicated across the word and mbe picks the lanes.
  always_comb begin
    case (funct3)
      rv32i_pkg::F3_B, rv32i_pkg::F3_BU: begin
        wdata = {4{rs2[7:0]}};
        case (addr_lo)
          2'b00:   mbe = 4'b0001;
          2'b01:   mbe = 4'b0010;
          2'b10:   mbe = 4'b0100;
          default: mbe = 4'b1000;
        endcase
      end
      rv32i_pkg::F3_H, rv32i_pkg::F3_HU: begin
        wdata = {2{rs2[15:0]}};
        if (addr_lo[1]) begin
          mbe = 4'b1100; // upper half.
        end else begin
          mbe = 4'b0011; // lower half.
        end
      end
      default: begin
        wdata = rs2; // word store.
        mbe   = 4'b1111;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hw/memory_access.sv
`timescale 1ns/1ps
`default_nettype none

module memory_access (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire rv32i_pkg::word_t     pc_in,
  input  wire rv32i_pkg::word_t     alu_in,
  input  wire rv32i_pkg::word_t     rs2_in,
  input  wire rv32i_pkg::ctrl_word_t ctrl_in,
  input  wire logic                 br_en_in,
  dmem_if.stage                     bus,
  output logic                      ma_stall,
  output rv32i_pkg::ctrl_word_t     ctrl_out,
  output rv32i_pkg::word_t          alu_out,
  output rv32i_pkg::word_t          rdata_out,
  output rv32i_pkg::word_t          pc_plus4_out,
  output logic                      br_en_out
);

  rv32i_pkg::word_t store_wdata;
  logic [3:0]       store_mbe;

  // ******************************
  // data bus request
  // ******************************

  store_align u_align (
    .funct3  (ctrl_in.funct3),
    .addr_lo (alu_in[1:0]),
    .rs2     (rs2_in),
    .wdata   (store_wdata),
    .mbe     (store_mbe)
  );

  assign bus.addr  = {alu_in[31:2], 2'b00}; // word aligned.
  assign bus.wdata = store_wdata;
  assign bus.mbe   = store_mbe;
  assign bus.read  = ctrl_in.mem_read;
  assign bus.write = ctrl_in.mem_write;

  // hold the front of the pipe until the memory answers.
  assign ma_stall = (ctrl_in.mem_read || ctrl_in.mem_write) && !bus.resp;

  // ******************************
  // mem/wb register
  // ******************************

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl_out     <= '0; // bubble.
      alu_out      <= '0;
      rdata_out    <= '0;
      pc_plus4_out <= '0;
      br_en_out    <= 1'b0;
    end else if (!ma_stall) begin
      ctrl_out     <= ctrl_in;
      alu_out      <= alu_in;       // low bits kept for load extraction.
      rdata_out    <= bus.rdata;    // valid on the resp edge.
      pc_plus4_out <= pc_in + 32'd4;
      br_en_out    <= br_en_in;
    end
  end

  // a control word is either a load or a store, never both.
  a_one_request : assert property (
    @(posedge clk) disable iff (rst)
    !(bus.read && bus.write)
  );

endmodule

`default_nettype wire

// File: hw/data_sram.sv
`timescale 1ns/1ps
`default_nettype none

module data_sram #(
  parameter int MEM_WORDS   = 256,
  parameter int WAIT_STATES = 2
) (
  input wire logic clk,
  input wire logic rst,
  dmem_if.mem      bus
);

  localparam int AW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  localparam int CW = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

  rv32i_pkg::word_t mem [MEM_WORDS];
  logic [AW-1:0]    idx;
  logic [CW-1:0]    wait_cnt;
  logic             req;

  assign req = bus.read || bus.write;
  assign idx = bus.addr[AW+1:2]; // word index.

  // ******************************
  // wait state counter
  // ******************************

  // counts full cycles of a held request; resp ends the access.
  always_ff @(posedge clk) begin
    if (rst) begin
      wait_cnt <= '0;
    end else if (bus.resp || !req) begin
      wait_cnt <= '0;
    end else begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  assign bus.resp  = req && (wait_cnt == CW'(WAIT_STATES));
  assign bus.rdata = mem[idx];

  // ******************************
  // byte enabled write
  // ******************************

  always_ff @(posedge clk) begin
    if (bus.resp && bus.write) begin
      for (int i = 0; i < 4; i++) begin
        if (bus.mbe[i]) begin
          mem[idx][8*i +: 8] <= bus.wdata[8*i +: 8];
        end
      end
    end
  end

  // a pending request stays up and unchanged until resp.
  a_req_held : assert property (
    @(posedge clk) disable iff (rst)
    (req && !bus.resp) |=> (req && $stable({bus.read, bus.write, bus.addr}))
  );

  // the stage must only reach words that exist.
  a_addr_in_range : assert property (
    @(posedge clk) disable iff (rst)
    req |-> (bus.addr[31:2] < MEM_WORDS)
  );

endmodule

`default_nettype wire

// File: hw/writeback.sv
`timescale 1ns/1ps
`default_nettype none

module writeback (
  input  wire rv32i_pkg::ctrl_word_t ctrl,
  input  wire rv32i_pkg::word_t      alu_out,
  input  wire rv32i_pkg::word_t      rdata,
  input  wire rv32i_pkg::word_t      pc_plus4,
  input  wire logic                  br_en,
  output logic [4:0]                 rd,
  output rv32i_pkg::word_t           rd_wdata,
  output logic                       rd_we
);

  rv32i_pkg::word_t shifted;
  rv32i_pkg::word_t load_val;

  // ******************************
  // load extraction
  // ******************************

  // bring the addressed lane down to bit 0.
  assign shifted = rdata >> {alu_out[1:0], 3'b000};

  always_comb begin
    case (ctrl.funct3)
      rv32i_pkg::F3_B:  load_val = {{24{shifted[7]}}, shifted[7:0]};
      rv32i_pkg::F3_BU: load_val = {24'd0, shifted[7:0]};
      rv32i_pkg::F3_H:  load_val = {{16{shifted[15]}}, shifted[15:0]};
      rv32i_pkg::F3_HU: load_val = {16'd0, shifted[15:0]};
      default:          load_val = rdata; // word load.
    endcase
  end

  // ******************************
  // register write select
  // ******************************

  always_comb begin
    case (ctrl.rd_src)
      rv32i_pkg::rd_load: rd_wdata = load_val;
      rv32i_pkg::rd_pc4:  rd_wdata = pc_plus4;
      rv32i_pkg::rd_br:   rd_wdata = {31'd0, br_en};
      default:            rd_wdata = alu_out;
    endcase
  end

  assign rd    = ctrl.rd;
  assign rd_we = ctrl.reg_we && (ctrl.rd != 5'd0); // x0 is hardwired.

endmodule

`default_nettype wire

// File: hw/mem_wb_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_top #(
  parameter int MEM_WORDS   = 256,
  parameter int WAIT_STATES = 2
) (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire rv32i_pkg::word_t      pc_in,
  input  wire rv32i_pkg::ctrl_word_t ctrl_in,
  input  wire rv32i_pkg::word_t      alu_in,
  input  wire rv32i_pkg::word_t      rs2_in,
  input  wire logic                  br_en_in,
  output logic                       ma_stall,
  output logic [4:0]                 rd,
  output rv32i_pkg::word_t           rd_wdata,
  output logic                       rd_we
);

  rv32i_pkg::ctrl_word_t ctrl_q;
  rv32i_pkg::word_t      alu_q;
  rv32i_pkg::word_t      rdata_q;
  rv32i_pkg::word_t      pc4_q;
  logic                  br_q;

  dmem_if dbus ();

  memory_access u_mem_access (
    .clk          (clk),
    .rst          (rst),
    .pc_in        (pc_in),
    .alu_in       (alu_in),
    .rs2_in       (rs2_in),
    .ctrl_in      (ctrl_in),
    .br_en_in     (br_en_in),
    .bus          (dbus.stage),
    .ma_stall     (ma_stall),
    .ctrl_out     (ctrl_q),
    .alu_out      (alu_q),
    .rdata_out    (rdata_q),
    .pc_plus4_out (pc4_q),
    .br_en_out    (br_q)
  );

  data_sram #(
    .MEM_WORDS   (MEM_WORDS),
    .WAIT_STATES (WAIT_STATES)
  ) u_dmem (
    .clk (clk),
    .rst (rst),
    .bus (dbus.mem)
  );

  writeback u_writeback (
    .ctrl     (ctrl_q),
    .alu_out  (alu_q),
    .rdata    (rdata_q),
    .pc_plus4 (pc4_q),
    .br_en    (br_q),
    .rd       (rd),
    .rd_wdata (rd_wdata),
    .rd_we    (rd_we)
  );

endmodule

`default_nettype wire

// File: bench/tb_mem_wb.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_wb;

  localparam int MEM_WORDS   = 256;
  localparam int WAIT_STATES = 2;
  localparam int MAX_CYCLES  = 2000; // about ten times the test length.

  logic                  clk;
  logic                  rst;
  logic [31:0]           pc_in;
  rv32i_pkg::ctrl_word_t ctrl_in;
  logic [31:0]           alu_in;
  logic [31:0]           rs2_in;
  logic                  br_en_in;
  logic                  ma_stall;
  logic [4:0]            rd;
  logic [31:0]           rd_wdata;
  logic                  rd_we;

  logic [7:0]  ref_mem [MEM_WORDS*4]; // byte view of the data memory.
  integer      seed;
  int          last_stalls;
  int          cycle_count;
  int          error_count;
  logic [31:0] pc_seq;

  mem_wb_top #(
    .MEM_WORDS   (MEM_WORDS),
    .WAIT_STATES (WAIT_STATES)
  ) UUT (
    .clk      (clk),
    .rst      (rst),
    .pc_in    (pc_in),
    .ctrl_in  (ctrl_in),
    .alu_in   (alu_in),
    .rs2_in   (rs2_in),
    .br_en_in (br_en_in),
    .ma_stall (ma_stall),
    .rd       (rd),
    .rd_wdata (rd_wdata),
    .rd_we    (rd_we)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display(">>> FAIL");
      $fatal(1, "simulation timed out");
    end
  end

  // ******************************
  // helpers
  // ******************************

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      error_count++;
      $display("MISMATCH %s: got %h, expected %h", name, actual, expected);
      $display(">>> FAIL");
      $fatal(1, "stopped at first error");
    end
  endtask

  function automatic rv32i_pkg::ctrl_word_t ctrl_word(
    input logic rd_en, input logic wr_en, input logic [2:0] f3,
    input rv32i_pkg::rd_src_t src, input logic [4:0] dest, input logic we);
    rv32i_pkg::ctrl_word_t c;
    c.mem_read  = rd_en;
    c.mem_write = wr_en;
    c.funct3    = f3;
    c.rd_src    = src;
    c.rd        = dest;
    c.reg_we    = we;
    return c;
  endfunction

  // drive at edge plus 2 ns, return 2 ns after the accepting edge.
  task automatic issue(input rv32i_pkg::ctrl_word_t c, input logic [31:0] pc,
                       input logic [31:0] alu, input logic [31:0] rs2, input logic br);
    ctrl_in     = c;
    pc_in       = pc;
    alu_in      = alu;
    rs2_in      = rs2;
    br_en_in    = br;
    pc_seq      = pc_seq + 32'd4;
    last_stalls = 0;
    #1;
    while (ma_stall) begin
      last_stalls++;
      @(posedge clk);
      #3;
    end
    @(posedge clk); // acceptance edge.
    #2;
  endtask

  task automatic store_ref(input logic [31:0] addr, input logic [2:0] f3,
                           input logic [31:0] data);
    int hb;
    int wb;
    hb = int'(addr & ~32'd1);
    wb = int'(addr & ~32'd3);
    case (f3)
      rv32i_pkg::F3_B, rv32i_pkg::F3_BU: ref_mem[int'(addr)] = data[7:0];
      rv32i_pkg::F3_H, rv32i_pkg::F3_HU: begin
        ref_mem[hb]   = data[7:0];
        ref_mem[hb+1] = data[15:8];
      end
      default: begin
        for (int i = 0; i < 4; i++) begin
          ref_mem[wb+i] = data[8*i +: 8];
        end
      end
    endcase
  endtask

  function automatic logic [31:0] load_ref(input logic [31:0] addr, input logic [2:0] f3);
    logic [7:0]  b;
    logic [15:0] h;
    int          hb;
    int          wb;
    hb = int'(addr & ~32'd1);
    wb = int'(addr & ~32'd3);
    b  = ref_mem[int'(addr)];
    h  = {ref_mem[hb+1], ref_mem[hb]};
    case (f3)
      rv32i_pkg::F3_B:  return {{24{b[7]}}, b};
      rv32i_pkg::F3_BU: return {24'd0, b};
      rv32i_pkg::F3_H:  return {{16{h[15]}}, h};
      rv32i_pkg::F3_HU: return {16'd0, h};
      default:          return {ref_mem[wb+3], ref_mem[wb+2], ref_mem[wb+1], ref_mem[wb]};
    endcase
  endfunction

  task automatic mem_store(input logic [31:0] addr, input logic [2:0] f3,
                           input logic [31:0] data);
    issue(ctrl_word(1'b0, 1'b1, f3, rv32i_pkg::rd_alu, 5'd0, 1'b0), pc_seq, addr, data, 1'b0);
    check("ma_stall cycles", last_stalls, WAIT_STATES);
    check("rd_we", 32'(rd_we), 32'd0);
    store_ref(addr, f3, data);
  endtask

  task automatic mem_load(input logic [31:0] addr, input logic [2:0] f3, input logic [4:0] dest);
    issue(ctrl_word(1'b1, 1'b0, f3, rv32i_pkg::rd_load, dest, 1'b1), pc_seq, addr,
          $random(seed), 1'b0);
    check("ma_stall cycles", last_stalls, WAIT_STATES);
    check("rd", 32'(rd), 32'(dest));
    check("rd_we", 32'(rd_we), 32'(dest != 5'd0));
    check("rd_wdata", rd_wdata, load_ref(addr, f3));
  endtask

  task automatic alu_write(input logic [4:0] dest, input logic [31:0] value);
    issue(ctrl_word(1'b0, 1'b0, rv32i_pkg::F3_W, rv32i_pkg::rd_alu, dest, 1'b1), pc_seq,
          value, $random(seed), 1'b0);
    check("ma_stall cycles", last_stalls, 0);
    check("rd", 32'(rd), 32'(dest));
    check("rd_we", 32'(rd_we), 32'(dest != 5'd0)); // x0 never written.
    check("rd_wdata", rd_wdata, value);
  endtask

  // ******************************
  // tests
  // ******************************

  task automatic alu_stream();
    check("rd_we after reset", 32'(rd_we), 32'd0);
    for (int i = 1; i <= 4; i++) begin
      alu_write(5'(i), $random(seed));
    end
    alu_write(5'd0, $random(seed));
  endtask

  task automatic word_round_trip();
    logic [31:0] addr;
    for (int i = 0; i < 4; i++) begin
      addr = 32'h100 + 32'(i * 12);
      mem_store(addr, rv32i_pkg::F3_W, $random(seed));
      mem_load(addr, rv32i_pkg::F3_W, 5'd11);
    end
    mem_store(32'h3fc, rv32i_pkg::F3_W, $random(seed)); // last word.
    mem_load(32'h3fc, rv32i_pkg::F3_W, 5'd12);
  endtask

  task automatic partial_stores();
    mem_store(32'h40, rv32i_pkg::F3_W, $random(seed));
    for (int off = 0; off < 4; off++) begin
      mem_store(32'h40 + 32'(off), rv32i_pkg::F3_B, $random(seed));
      mem_load(32'h40, rv32i_pkg::F3_W, 5'd7);
    end
    for (int off = 0; off < 4; off += 2) begin
      mem_store(32'h40 + 32'(off), rv32i_pkg::F3_H, $random(seed));
      mem_load(32'h40, rv32i_pkg::F3_W, 5'd8);
    end
  endtask

  task automatic partial_loads();
    mem_store(32'h80, rv32i_pkg::F3_W, 32'h80ff_7f01); // both sign cases.
    mem_store(32'h84, rv32i_pkg::F3_W, $random(seed));
    for (int w = 0; w < 8; w += 4) begin
      for (int off = 0; off < 4; off++) begin
        mem_load(32'h80 + 32'(w + off), rv32i_pkg::F3_B, 5'd9);
        mem_load(32'h80 + 32'(w + off), rv32i_pkg::F3_BU, 5'd10);
      end
      for (int off = 0; off < 4; off += 2) begin
        mem_load(32'h80 + 32'(w + off), rv32i_pkg::F3_H, 5'd13);
        mem_load(32'h80 + 32'(w + off), rv32i_pkg::F3_HU, 5'd14);
      end
    end
  endtask

  task automatic link_and_branch();
    logic [31:0] pc;
    pc = $random(seed);
    issue(ctrl_word(1'b0, 1'b0, 3'd0, rv32i_pkg::rd_pc4, 5'd1, 1'b1), pc, $random(seed),
          $random(seed), 1'b1);
    check("rd_wdata", rd_wdata, pc + 32'd4);
    for (int b = 1; b >= 0; b--) begin
      issue(ctrl_word(1'b0, 1'b0, 3'd0, rv32i_pkg::rd_br, 5'd2, 1'b1), pc_seq, $random(seed),
            $random(seed), 1'(b));
      check("ma_stall cycles", last_stalls, 0);
      check("rd_wdata", rd_wdata, 32'(b));
    end
  endtask

  task automatic mixed_traffic();
    mem_store(32'h200, rv32i_pkg::F3_W, $random(seed));
    alu_write(5'd3, $random(seed));
    mem_load(32'h200, rv32i_pkg::F3_W, 5'd4);
    mem_store(32'h201, rv32i_pkg::F3_B, $random(seed));
    alu_write(5'd5, $random(seed));
    mem_load(32'h200, rv32i_pkg::F3_W, 5'd6);
    mem_load(32'h203, rv32i_pkg::F3_BU, 5'd7);
    alu_write(5'd0, $random(seed));
    mem_load(32'h202, rv32i_pkg::F3_H, 5'd8);
  endtask

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    pc_in       = '0;
    ctrl_in     = '0; // bubble.
    alu_in      = '0;
    rs2_in      = '0;
    br_en_in    = 1'b0;
    seed        = 32'hc14b_7b86;
    cycle_count = 0;
    error_count = 0;
    pc_seq      = 32'h0000_1000;
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;
    alu_stream();
    word_round_trip();
    partial_stores();
    partial_loads();
    link_and_branch();
    mixed_traffic();
    ctrl_in = '0;
    if (error_count == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display(">>> FAIL");
      $fatal(1, "checks failed");
    end
  end

endmodule

`default_nettype wire

// File: mem_wb_top.f
hw/rv32i_pkg.sv
hw/dmem_if.sv
hw/store_align.sv
hw/memory_access.sv
hw/data_sram.sv
hw/writeback.sv
hw/mem_wb_top.sv
bench/tb_mem_wb.sv

// File: Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_mem_wb
FILELIST   = mem_wb_top.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q ">>> PASS" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
